//--- sources.f
+incdir+include
design/shrg_pkg.sv
design/shrg_line_sequencer.sv
design/shrg_fetch_addr.sv
design/shrg_palette.sv
design/shrg_pixel_decode.sv
design/shrg_video_out.sv
design/shrg_vgc_top.sv
bench/shrg_tb.sv

//--- run.sh
#!/bin/sh
# Build the SHR VGC testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module shrg_tb -f sources.f -o vshrg_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi
./obj_dir/vshrg_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
echo "Simulation reported errors, see sim.log"
exit 1

//--- include/shrg_tb_tasks.svh
`ifndef SHRG_TB_TASKS_SVH
`define SHRG_TB_TASKS_SVH

task automatic check_chan(input string test_name, input string what,
                          input chan8_t exp, input chan8_t act);
    if (exp !== act) begin
        $display("Fail %s %s: expected %02h, actual %02h", test_name, what, exp, act);
        test_errors++;
    end
endtask

task automatic check_count(input string test_name, input string what,
                           input int exp, input int act);
    if (exp != act) begin
        $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        test_errors++;
    end
endtask

// 4-bit channel repeated into both nibbles
function automatic chan8_t to_chan8(chan4_t c);
    return {c, c};
endfunction

task automatic check_rgb(input string test_name, input string what, input rgb12_t exp);
    check_chan(test_name, {what, " r"}, to_chan8(exp[11:8]), r);
    check_chan(test_name, {what, " g"}, to_chan8(exp[7:4]), g);
    check_chan(test_name, {what, " b"}, to_chan8(exp[3:0]), b);
endtask

// Falling edges only, where outputs are settled
task automatic wait_beam(input int v, input int h);
    do begin
        @(negedge clk_vid);
    end while (!(v_pos == v_pos_t'(v) && h_pos == h_pos_t'(h)));
endtask

task automatic end_test(input string test_name);
    tests_run++;
    if (test_errors == 0) begin
        $display("%s: passed", test_name);
    end else begin
        $display("%s: failed with %0d errors", test_name, test_errors);
        tests_failed++;
    end
    check_errors += test_errors;
    test_errors = 0;
endtask

task automatic test_border(input color_idx_t k);
    @(posedge clk_vid);
    border_color <= k;
    // Every sample of a blank line
    wait_beam(20, 0);
    repeat (line_clks) begin
        check_rgb("border", "line 20", iigs_border_rgb[k]);
        @(negedge clk_vid);
    end
    // Left and right border of an active line
    wait_beam(35, 10);
    check_rgb("border", "line 35 h 10", iigs_border_rgb[k]);
    wait_beam(35, 700);
    check_rgb("border", "line 35 h 700", iigs_border_rgb[k]);
    end_test("border");
endtask

task automatic test_solid_320();
    wait_beam(40, 200);
    check_rgb("solid 320", "h 200", palette_color(3, 5));
    wait_beam(40, 400);
    check_rgb("solid 320", "h 400", palette_color(3, 5));
    end_test("solid 320");
endtask

// Byte 0x70 then zeros on palette 5
task automatic test_fill_line(input string test_name, input int line, input int entry);
    wait_beam(line, 100);
    repeat (501) begin
        check_rgb(test_name, "middle", palette_color(5, entry));
        @(negedge clk_vid);
    end
    end_test(test_name);
endtask

task automatic test_mode_640();
    rgb12_t seen [$];
    rgb12_t c;
    logic   hit;
    int     entries [4] = '{8, 12, 0, 4};
    wait_beam(60, 100);
    // Distinct colors over the middle of the line
    repeat (501) begin
        c   = {r[7:4], g[7:4], b[7:4]};
        hit = 1'b0;
        foreach (seen[i]) begin
            hit = hit | (seen[i] == c);
        end
        if (!hit) begin
            seen.push_back(c);
        end
        @(negedge clk_vid);
    end
    check_count("mode 640", "distinct colors", 4, seen.size());
    foreach (entries[e]) begin
        hit = 1'b0;
        foreach (seen[i]) begin
            hit = hit | (seen[i] == palette_color(6, entries[e]));
        end
        check_count("mode 640", $sformatf("entry %0d seen", entries[e]), 1, int'(hit));
    end
    end_test("mode 640");
endtask

// SCB read during line v asks for an interrupt on line v + 1
function automatic int expected_scanline_irqs();
    int        cnt = 0;
    vid_byte_t scb;
    for (int v = 0; v < frame_lines; v++) begin
        scb = read_mem(scb_addr(v + 1));
        if (scb[6] && v + 1 >= `SHR_V_FIRST && v + 1 <= irq_last_line) begin
            cnt++;
        end
    end
    return cnt;
endfunction

task automatic test_interrupts();
    int   sl_count = 0;
    int   vbl_count = 0;
    logic sl_prev = 1'b0;
    logic vbl_prev = 1'b0;
    // One whole frame
    wait_beam(0, 0);
    do begin
        if (scanline_irq) begin
            sl_count++;
            if (sl_prev) begin
                $display("interrupts: scanline_irq stayed high for two cycles in a row");
                test_errors++;
            end
        end
        if (vbl_irq) begin
            vbl_count++;
            if (vbl_prev) begin
                $display("interrupts: vbl_irq stayed high for two cycles in a row");
                test_errors++;
            end
        end
        sl_prev  = scanline_irq;
        vbl_prev = vbl_irq;
        @(negedge clk_vid);
    end while (!(v_pos == '0 && h_pos == '0));
    check_count("interrupts", "scanline_irq pulses", expected_scanline_irqs(), sl_count);
    check_count("interrupts", "vbl_irq pulses", 1, vbl_count);
    end_test("interrupts");
endtask

`endif

//--- bench/shrg_tb.sv
`timescale 1ns/1ps

`include "shrg_defs.svh"

module shrg_tb import shrg_pkg::*; ();

    localparam int clk_period  = 20;
    localparam int frame_lines = 262;
    localparam int line_clks   = 912;
    // Last line that may raise a scanline interrupt
    localparam int irq_last_line = 205;
    // Two frames of tests, plus reset and margin
    localparam int run_lines = 2 * frame_lines + 16;

    // Standard IIgs 16-color set for the border
    localparam rgb12_t iigs_border_rgb [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

    logic       clk_vid = 1'b0;
    logic       rst_n = 1'b0;
    logic       ce_pix = 1'b1;
    h_pos_t     h_pos = '0;
    v_pos_t     v_pos = '0;
    vid_byte_t  video_data = '0;
    color_idx_t border_color = 4'd0;
    vid_addr_t  video_addr;
    chan8_t     r;
    chan8_t     g;
    chan8_t     b;
    logic       scanline_irq;
    logic       vbl_irq;

    // Sparse video memory, unwritten bytes read as zero
    vid_byte_t mem [vid_addr_t];
    int        seed = 32'h79b3_5f9c;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        check_errors = 0;
    int        test_errors = 0;

    shrg_vgc_top dut_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix),
        .h_pos(h_pos), .v_pos(v_pos), .video_data(video_data),
        .border_color(border_color), .video_addr(video_addr), .r(r), .g(g), .b(b),
        .scanline_irq(scanline_irq), .vbl_irq(vbl_irq));

    always #(clk_period / 2) clk_vid = ~clk_vid;

    // Beam generator, 912 clocks per line
    always @(posedge clk_vid) begin
        if (h_pos == h_pos_t'(line_clks - 1)) begin
            h_pos <= '0;
            v_pos <= (v_pos == v_pos_t'(frame_lines - 1)) ? '0 : v_pos + 1'b1;
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    function automatic vid_byte_t read_mem(vid_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return 8'h00;
    endfunction

    // Memory answers the address it saw one edge later
    always @(posedge clk_vid) begin
        video_data <= read_mem(video_addr);
    end

    // SCB byte that belongs to a display line
    function automatic vid_addr_t scb_addr(int line);
        return `SHR_SCB_BASE + vid_addr_t'(line - `SHR_V_FIRST);
    endfunction

    function automatic vid_addr_t pix_addr(int line, int i);
        return `SHR_PIX_BASE + vid_addr_t'(`SHR_LINE_BYTES * (line - `SHR_V_FIRST) + i);
    endfunction

    // Entry n of palette p, even byte green and blue, odd byte red in the low nibble
    function automatic rgb12_t palette_color(int p, int n);
        vid_addr_t a;
        vid_byte_t gb;
        vid_byte_t rb;
        a  = `SHR_PAL_BASE + vid_addr_t'(32 * p + 2 * n);
        gb = read_mem(a);
        rb = read_mem(a + 1'b1);
        return {rb[3:0], gb};
    endfunction

    task automatic fill_line(int line, vid_byte_t val);
        for (int i = 0; i < `SHR_LINE_BYTES; i++) begin
            mem[pix_addr(line, i)] = val;
        end
    endtask

    task automatic load_memory();
        rgb12_t    c;
        logic      dup;
        vid_addr_t a;
        // Random palettes, colors kept distinct within each palette
        for (int p = 0; p < 16; p++) begin
            for (int n = 0; n < 16; n++) begin
                do begin
                    c   = rgb12_t'($random(seed));
                    dup = 1'b0;
                    for (int k = 0; k < n; k++) begin
                        dup = dup | (palette_color(p, k) == c);
                    end
                end while (dup);
                a = `SHR_PAL_BASE + vid_addr_t'(32 * p + 2 * n);
                mem[a] = c[7:0];
                // Unused high nibble of the red byte gets junk
                mem[a + 1'b1] = {4'($random(seed)), c[11:8]};
            end
        end
        // Solid 320, fill on and off, 640 mode
        mem[scb_addr(40)] = 8'h03;
        mem[scb_addr(50)] = 8'h25;
        mem[scb_addr(51)] = 8'h05;
        mem[scb_addr(60)] = 8'h86;
        // Interrupt requests, lines 31 and 206 fall outside the range
        mem[scb_addr(31)]  = 8'h40;
        mem[scb_addr(45)]  = 8'h40;
        mem[scb_addr(100)] = 8'h4a;
        mem[scb_addr(205)] = 8'h40;
        mem[scb_addr(206)] = 8'h40;
        fill_line(40, 8'h55);
        fill_line(50, 8'h00);
        fill_line(51, 8'h00);
        fill_line(60, 8'h00);
        mem[pix_addr(50, 0)] = 8'h70;
        mem[pix_addr(51, 0)] = 8'h70;
    endtask

    // Timeout
    initial begin
        #(run_lines * line_clks * clk_period);
        $display("Timeout: tests did not finish within %0d lines", run_lines);
        $display("Finished with errors");
        $finish;
    end

`include "shrg_tb_tasks.svh"

    initial begin
        load_memory();
        repeat (10) @(posedge clk_vid);
        rst_n <= 1'b1;
        test_border(4'd9);
        test_solid_320();
        test_fill_line("fill on", 50, 7);
        test_fill_line("fill off", 51, 0);
        test_mode_640();
        test_interrupts();
        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, check_errors);
        if (tests_failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- design/shrg_vgc_top.sv
`timescale 1ns/1ps

module shrg_vgc_top import shrg_pkg::*; (
    input  logic       clk_vid,
    input  logic       rst_n,
    input  logic       ce_pix,
    input  h_pos_t     h_pos,
    input  v_pos_t     v_pos,
    input  vid_byte_t  video_data,
    input  color_idx_t border_color,
    output vid_addr_t  video_addr,
    output chan8_t     r,
    output chan8_t     g,
    output chan8_t     b,
    output logic       scanline_irq,
    output logic       vbl_irq
);

    line_phase_t phase;
    logic        mode640;
    logic        fill_en;
    color_idx_t  pal_sel;
    logic [1:0]  pix_phase;
    color_idx_t  rd_idx;
    rgb12_t      rd_rgb;
    rgb12_t      pix_rgb;

    // Line phases, SCB and interrupts
    shrg_line_sequencer seq_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix),
        .h_pos(h_pos), .v_pos(v_pos), .video_data(video_data), .phase(phase),
        .mode640(mode640), .fill_en(fill_en), .pal_sel(pal_sel),
        .scanline_irq(scanline_irq), .vbl_irq(vbl_irq));

    shrg_fetch_addr addr_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix),
        .phase(phase), .pal_sel(pal_sel), .v_pos(v_pos), .video_addr(video_addr),
        .pix_phase(pix_phase));

    shrg_palette pal_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix), .phase(phase),
        .video_data(video_data), .rd_idx(rd_idx), .rd_rgb(rd_rgb));

    shrg_pixel_decode dec_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix),
        .phase(phase), .pix_phase(pix_phase), .mode640(mode640), .fill_en(fill_en),
        .video_data(video_data), .rd_rgb(rd_rgb), .rd_idx(rd_idx), .pix_rgb(pix_rgb));

    // Border and final RGB registers
    shrg_video_out out_i (.clk_vid(clk_vid), .rst_n(rst_n), .ce_pix(ce_pix),
        .h_pos(h_pos), .v_pos(v_pos), .border_color(border_color), .pix_rgb(pix_rgb),
        .r(r), .g(g), .b(b));

endmodule

//--- design/shrg_video_out.sv
`timescale 1ns/1ps

`include "shrg_defs.svh"

module shrg_video_out import shrg_pkg::*; (
    input  logic       clk_vid,
    input  logic       rst_n,
    input  logic       ce_pix,
    input  h_pos_t     h_pos,
    input  v_pos_t     v_pos,
    input  color_idx_t border_color,
    input  rgb12_t     pix_rgb,
    output chan8_t     r,
    output chan8_t     g,
    output chan8_t     b
);

    // Standard IIgs 16-color set, black through white
    localparam rgb12_t iigs_colors [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

    logic   in_window;
    rgb12_t out_rgb;

    // Full 4-bit range maps onto full 8-bit range
    function automatic chan8_t widen(chan4_t c);
        return {c, c};
    endfunction

    assign in_window = (h_pos >= h_pos_t'(`SHR_H_WIN_FIRST)) &&
                       (h_pos <= h_pos_t'(`SHR_H_WIN_LAST)) &&
                       (v_pos >= v_pos_t'(`SHR_V_FIRST)) &&
                       (v_pos <= v_pos_t'(`SHR_V_LAST));

    assign out_rgb = in_window ? pix_rgb : iigs_colors[border_color];

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else if (ce_pix) begin
            r <= widen(out_rgb[11:8]);
            g <= widen(out_rgb[7:4]);
            b <= widen(out_rgb[3:0]);
        end
    end

endmodule

//--- design/shrg_pixel_decode.sv
`timescale 1ns/1ps

module shrg_pixel_decode import shrg_pkg::*; (
    input  logic        clk_vid,
    input  logic        rst_n,
    input  logic        ce_pix,
    input  line_phase_t phase,
    input  logic [1:0]  pix_phase,
    input  logic        mode640,
    input  logic        fill_en,
    input  vid_byte_t   video_data,
    input  rgb12_t      rd_rgb,
    output color_idx_t  rd_idx,
    output rgb12_t      pix_rgb
);

    color_idx_t nibble;
    color_idx_t last_idx;
    logic [1:0] pair;
    logic       load;

    // 320 mode, left pixel in the high nibble
    assign nibble = pix_phase[1] ? video_data[3:0] : video_data[7:4];

    // 640 mode, four 2-bit pixels left to right
    always_comb begin
        case (pix_phase)
            2'd0:    pair = video_data[7:6];
            2'd1:    pair = video_data[5:4];
            2'd2:    pair = video_data[3:2];
            default: pair = video_data[1:0];
        endcase
    end

    always_comb begin
        if (mode640) begin
            // Each column has its own group of four entries: 8, 12, 0, 4
            rd_idx = {~pix_phase[1], pix_phase[0], pair};
        end else if (fill_en && nibble == '0) begin
            // Fill mode repeats the last nonzero color
            rd_idx = last_idx;
        end else begin
            rd_idx = nibble;
        end
    end

    // 320 mode only takes a new color on the even clocks
    assign load = (phase == PH_PIXELS) && (mode640 || !pix_phase[0]);

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            last_idx <= '0;
        end else if (ce_pix && load && !mode640 && nibble != '0) begin
            last_idx <= nibble;
        end
    end

    // Registered color for the output stage
    always_ff @(posedge clk_vid) begin
        if (ce_pix && load) begin
            pix_rgb <= rd_rgb;
        end
    end

endmodule

//--- design/shrg_palette.sv
`timescale 1ns/1ps

module shrg_palette import shrg_pkg::*; (
    input  logic        clk_vid,
    input  logic        rst_n,
    input  logic        ce_pix,
    input  line_phase_t phase,
    input  vid_byte_t   video_data,
    input  color_idx_t  rd_idx,
    output rgb12_t      rd_rgb
);

    rgb12_t     pal_mem [16];
    color_idx_t entry;
    // Low when the next byte is the green/blue byte of an entry
    logic       byte_odd;

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                pal_mem[i] <= '0;
            end
            entry    <= '0;
            byte_odd <= 1'b0;
        end else if (ce_pix) begin
            if (phase == PH_PAL_START) begin
                entry    <= '0;
                byte_odd <= 1'b0;
            end else if (phase == PH_PALETTE) begin
                byte_odd <= ~byte_odd;
                if (byte_odd) begin
                    // Red sits in the low nibble, high nibble unused
                    pal_mem[entry][11:8] <= video_data[3:0];
                    entry                <= entry + 1'b1;
                end else begin
                    // Green high nibble, blue low nibble, same order as rgb12_t
                    pal_mem[entry][7:0] <= video_data;
                end
            end
        end
    end

    // Lookup for the decoder, read in the same enable
    assign rd_rgb = pal_mem[rd_idx];

    // Entry 15 red is the last palette byte, pixels must start right after it
    assert property (@(posedge clk_vid) disable iff (!rst_n)
        (ce_pix && phase == PH_PALETTE && byte_odd && entry == 4'hf)
            |=> (phase != PH_PALETTE));

endmodule

//--- design/shrg_fetch_addr.sv
`timescale 1ns/1ps

`include "shrg_defs.svh"

module shrg_fetch_addr import shrg_pkg::*; (
    input  logic        clk_vid,
    input  logic        rst_n,
    input  logic        ce_pix,
    input  line_phase_t phase,
    input  color_idx_t  pal_sel,
    input  v_pos_t      v_pos,
    output vid_addr_t   video_addr,
    output logic [1:0]  pix_phase
);

    vid_addr_t  scb_addr;
    vid_addr_t  pal_addr;
    vid_addr_t  line_base;
    v_pos_t     line_idx;
    // Runs through the palette bytes, then on through the pixel bytes
    logic [7:0] byte_cnt;

    // SCB of the line about to be displayed
    assign scb_addr = `SHR_SCB_BASE + vid_addr_t'(v_pos) - vid_addr_t'(`SHR_V_FIRST - 1);

    // 32 bytes per palette
    assign pal_addr = `SHR_PAL_BASE + vid_addr_t'(pal_sel) * vid_addr_t'(`SHR_PAL_BYTES);

    // Linear layout, 160 bytes per line
    assign line_idx  = v_pos - v_pos_t'(`SHR_V_FIRST);
    assign line_base = `SHR_PIX_BASE + vid_addr_t'(line_idx) * vid_addr_t'(`SHR_LINE_BYTES);

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            video_addr <= '0;
            byte_cnt   <= '0;
            pix_phase  <= '0;
        end else if (ce_pix) begin
            // Timer only runs inside the pixel phase
            pix_phase <= 2'd0;
            case (phase)
                PH_SCB_ADDR: begin
                    video_addr <= scb_addr;
                end
                PH_SCB_READ: begin
                    video_addr <= pal_addr;
                end
                PH_PAL_START: begin
                    video_addr <= video_addr + 1'b1;
                    byte_cnt   <= 8'd1;
                end
                PH_PALETTE: begin
                    // After the last palette address, park on the first pixel byte
                    if (byte_cnt == 8'(`SHR_PAL_BYTES - 1)) begin
                        video_addr <= line_base;
                        byte_cnt   <= 8'(`SHR_PAL_BYTES);
                    end else if (byte_cnt < 8'(`SHR_PAL_BYTES - 1)) begin
                        video_addr <= video_addr + 1'b1;
                        byte_cnt   <= byte_cnt + 1'b1;
                    end
                end
                PH_PIXELS: begin
                    pix_phase <= pix_phase + 1'b1;
                    // Step at phase 2 so the next byte lands with phase 0
                    if (pix_phase == 2'd2 &&
                        byte_cnt < 8'(`SHR_PAL_BYTES + `SHR_LINE_BYTES - 1)) begin
                        video_addr <= video_addr + 1'b1;
                        byte_cnt   <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Pixel fetch must never run into the next line's bytes
    assert property (@(posedge clk_vid) disable iff (!rst_n)
        (phase == PH_PIXELS) |-> (video_addr < line_base + vid_addr_t'(`SHR_LINE_BYTES)));

endmodule

//--- design/shrg_line_sequencer.sv
`timescale 1ns/1ps

`include "shrg_defs.svh"

module shrg_line_sequencer import shrg_pkg::*; (
    input  logic        clk_vid,
    input  logic        rst_n,
    input  logic        ce_pix,
    input  h_pos_t      h_pos,
    input  v_pos_t      v_pos,
    input  vid_byte_t   video_data,
    output line_phase_t phase,
    output logic        mode640,
    output logic        fill_en,
    output color_idx_t  pal_sel,
    output logic        scanline_irq,
    output logic        vbl_irq
);

    // Last line that may still raise a scanline interrupt
    localparam v_pos_t irq_line_last = v_pos_t'(205);

    line_phase_t phase_next;
    vid_byte_t   scb;
    v_pos_t      v_next;
    logic        irq_line_ok;
    logic        v_blank;
    logic        v_blank_d;

    // Phase decode from the beam, registered one enable later
    always_comb begin
        if (h_pos >= `SHR_H_SCB_ADDR && h_pos < `SHR_H_SCB_READ) begin
            // Address held until the read so memory sees it for a full enable
            phase_next = PH_SCB_ADDR;
        end else if (h_pos == `SHR_H_SCB_READ) begin
            phase_next = PH_SCB_READ;
        end else if (h_pos == `SHR_H_PAL_START - 10'd1) begin
            // Decoded one early so the phase is PH_PAL_START on the PAL_START clock,
            // which is h_pos 0 on a 912-clock line
            phase_next = PH_PAL_START;
        end else if (h_pos < h_pos_t'(`SHR_PAL_BYTES)) begin
            phase_next = PH_PALETTE;
        end else if (h_pos < h_pos_t'(`SHR_PAL_BYTES + `SHR_ACTIVE_W)) begin
            phase_next = PH_PIXELS;
        end else begin
            phase_next = PH_BLANK;
        end
    end

    // The SCB fetched here belongs to the next line
    assign v_next      = v_pos + 1'b1;
    assign irq_line_ok = (v_next >= v_pos_t'(`SHR_V_FIRST)) && (v_next <= irq_line_last);

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            phase        <= PH_BLANK;
            scb          <= '0;
            scanline_irq <= 1'b0;
            // Starts as if already blanking, so no strobe right out of reset
            v_blank_d    <= 1'b1;
        end else if (ce_pix) begin
            phase        <= phase_next;
            scanline_irq <= 1'b0;
            v_blank_d    <= v_blank;
            if (phase == PH_SCB_READ) begin
                scb          <= video_data;
                scanline_irq <= video_data[6] && irq_line_ok;
            end
        end
    end

    // SCB bit 7 selects 640 mode, bit 5 fill mode
    assign mode640 = scb[7];
    assign fill_en = scb[5];

    // Palette number goes straight from the bus on the read, the address needs it then
    assign pal_sel = (phase == PH_SCB_READ) ? video_data[3:0] : scb[3:0];

    // Strobe on the first enable of vertical blanking
    assign v_blank = (v_pos >= v_pos_t'(`SHR_V_VBL));
    assign vbl_irq = v_blank && !v_blank_d;

    // SCB read must come straight from its address phase or the data is stale
    assert property (@(posedge clk_vid) disable iff (!rst_n)
        (phase == PH_SCB_READ) |-> ($past(phase) inside {PH_SCB_ADDR, PH_SCB_READ}));

endmodule

//--- design/shrg_pkg.sv
package shrg_pkg;

    // Beam position from the external timing generator
    typedef logic [9:0] h_pos_t;
    typedef logic [8:0] v_pos_t;

    // Video memory bus
    typedef logic [22:0] vid_addr_t;
    typedef logic [7:0]  vid_byte_t;

    // Index into the 16-entry line palette
    typedef logic [3:0] color_idx_t;

    // One channel as stored in the palette, and as driven out
    typedef logic [3:0] chan4_t;
    typedef logic [7:0] chan8_t;

    // Palette color packed as {red, green, blue}
    typedef logic [11:0] rgb12_t;

    // Where the line is in its fetch sequence
    typedef enum logic [2:0] {
        // Nothing fetched, right border and retrace
        PH_BLANK,
        // SCB address on the bus
        PH_SCB_ADDR,
        // SCB byte on the data bus
        PH_SCB_READ,
        // First palette address on the bus
        PH_PAL_START,
        // 32 palette bytes streaming in
        PH_PALETTE,
        // 160 pixel bytes, one every four clocks
        PH_PIXELS
    } line_phase_t;

endpackage

//--- include/shrg_defs.svh
`ifndef SHRG_DEFS_SVH
`define SHRG_DEFS_SVH

// Horizontal points of the header fetch at the end of each line
`define SHR_H_SCB_ADDR   10'h38C
`define SHR_H_SCB_READ   10'h38E
`define SHR_H_PAL_START  10'h390

// Palette bytes per line, two per entry
`define SHR_PAL_BYTES    32

// Active pixel clocks per line
`define SHR_ACTIVE_W     640

// First and last active line
`define SHR_V_FIRST      32
`define SHR_V_LAST       231

// Output window, in h_pos of the sample
`define SHR_H_WIN_FIRST  33
`define SHR_H_WIN_LAST   672

// Vertical blanking interrupt line
`define SHR_V_VBL        199

// SHR memory layout in bank E1
`define SHR_SCB_BASE     23'h19D00
`define SHR_PAL_BASE     23'h19E00
`define SHR_PIX_BASE     23'h12000

// Pixel bytes per line, two 320-mode pixels each
`define SHR_LINE_BYTES   160

`endif
